//--- hw/adpcm_pkg.sv
// ADPCM-A fetch package with channel count, widths, tick divider, register map and shared types
package adpcm_pkg;

    localparam int num_ch  = 6;
    localparam int cen_div = 4;     // Clocks per pipeline tick

    localparam int bank_w  = 4;
    localparam int start_w = 12;    // Start and end page
    localparam int naddr_w = 21;    // Nibble address

    // CPU register map
    localparam logic [7:0] reg_key           = 8'h00;  // Bit 7 picks key-off
    localparam logic [7:0] reg_lvl_base      = 8'h08;
    localparam logic [7:0] reg_start_lo_base = 8'h10;
    localparam logic [7:0] reg_start_hi_base = 8'h18;
    localparam logic [7:0] reg_end_lo_base   = 8'h20;
    localparam logic [7:0] reg_end_hi_base   = 8'h28;

    typedef logic [num_ch-1:0] ch_mask_t;

    typedef struct packed {
        logic [1:0] pan;
        logic [4:0] level;
    } lvl_t;

endpackage

//--- hw/adpcm_wr_if.sv
// Write bus that carries address updates and key strobes into the address counter
`timescale 1ns/1ps
interface adpcm_wr_if;

    logic [15:0] addr_in;   // Bank in the top nibble, page below
    logic [2:0]  addr_ch;
    logic        up_start;
    logic        up_end;
    logic        aon;       // Key-on for the slot in stage 1
    logic        aoff;

    modport regs (
        output addr_in, addr_ch, up_start, up_end, aon, aoff
    );

    modport cnt (
        input  addr_in, addr_ch, up_start, up_end, aon, aoff
    );

endinterface

//--- hw/adpcm_ch_seq.sv
// Channel sequencer that makes the pipeline tick and rotates the one-hot slot ring
`timescale 1ns/1ps
module adpcm_ch_seq (
    input  logic                clk,
    input  logic                rst_n,
    output logic                cen,
    output adpcm_pkg::ch_mask_t cur_ch,
    output adpcm_pkg::ch_mask_t en_ch
);
    import adpcm_pkg::*;

    localparam int div_w = $clog2(cen_div);

    logic [div_w-1:0] div_cnt;

    assign cen   = (div_cnt == div_w'(cen_div - 1));
    assign en_ch = {cur_ch[1:0], cur_ch[num_ch-1:2]};  // Slot sitting in stage 5

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            cur_ch  <= ch_mask_t'(1);
        end else begin
            div_cnt <= cen ? '0 : div_cnt + 1'b1;
            if (cen)
                cur_ch <= {cur_ch[0], cur_ch[num_ch-1:1]};  // Next slot enters stage 1
        end
    end

endmodule

//--- hw/adpcm_cpu_regs.sv
// CPU register block that stages address writes and issues key strobes per slot
`timescale 1ns/1ps
module adpcm_cpu_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  adpcm_pkg::ch_mask_t cur_ch,
    input  logic                wr,
    input  logic [7:0]          reg_addr,
    input  logic [7:0]          din,
    adpcm_wr_if.regs            wr_bus
);
    import adpcm_pkg::*;

    logic [7:0] start_lo [num_ch];
    logic [7:0] start_hi [num_ch];
    logic [7:0] end_lo   [num_ch];
    logic [7:0] end_hi   [num_ch];
    ch_mask_t   pend_start;
    ch_mask_t   pend_end;
    ch_mask_t   pend_on;
    ch_mask_t   pend_off;
    logic [2:0] up_cnt;         // Ticks left in the current update round
    logic       up_is_end;
    logic [2:0] wr_ch;
    logic       ch_ok;
    ch_mask_t   wr_dec;
    logic       hit_start_hi;
    logic       hit_end_hi;
    ch_mask_t   key_m;
    ch_mask_t   key_on_m;
    ch_mask_t   key_off_m;
    ch_mask_t   slot_m;
    logic       pick_vld;
    logic       pick_end;
    logic [2:0] pick_ch;
    logic       launch;
    ch_mask_t   launch_m;

    assign wr_ch  = reg_addr[2:0];
    assign ch_ok  = wr_ch < 3'(num_ch);
    assign wr_dec = ch_ok ? ch_mask_t'(1) << wr_ch : '0;

    assign hit_start_hi = wr && ch_ok && (reg_addr[7:3] == reg_start_hi_base[7:3]);
    assign hit_end_hi   = wr && ch_ok && (reg_addr[7:3] == reg_end_hi_base[7:3]);

    assign key_m     = (wr && reg_addr == reg_key) ? din[num_ch-1:0] : '0;
    assign key_on_m  = din[7] ? '0 : key_m;
    assign key_off_m = din[7] ? key_m : '0;
    assign slot_m    = cen ? cur_ch : '0;   // Slot served on this tick

    // Lowest pending start first, then lowest pending end
    always_comb begin
        pick_vld = 1'b0;
        pick_end = 1'b0;
        pick_ch  = '0;
        for (int i = num_ch - 1; i >= 0; i--) begin
            if (pend_end[i]) begin
                pick_vld = 1'b1;
                pick_end = 1'b1;
                pick_ch  = 3'(i);
            end
        end
        for (int i = num_ch - 1; i >= 0; i--) begin
            if (pend_start[i]) begin
                pick_vld = 1'b1;
                pick_end = 1'b0;
                pick_ch  = 3'(i);
            end
        end
    end

    assign launch   = pick_vld && (up_cnt == '0);
    assign launch_m = launch ? ch_mask_t'(1) << pick_ch : '0;

    assign wr_bus.up_start = (up_cnt != '0) && !up_is_end;
    assign wr_bus.up_end   = (up_cnt != '0) && up_is_end;
    assign wr_bus.aon      = |(pend_on & cur_ch);
    assign wr_bus.aoff     = |(pend_off & cur_ch);

    always_ff @(posedge clk) begin
        if (wr && ch_ok) begin
            case (reg_addr[7:3])
                reg_start_lo_base[7:3]: start_lo[wr_ch] <= din;
                reg_start_hi_base[7:3]: start_hi[wr_ch] <= din;
                reg_end_lo_base[7:3]:   end_lo[wr_ch]   <= din;
                reg_end_hi_base[7:3]:   end_hi[wr_ch]   <= din;
                default: ;
            endcase
        end
        if (launch) begin
            wr_bus.addr_in <= pick_end ? {end_hi[pick_ch], end_lo[pick_ch]}
                                       : {start_hi[pick_ch], start_lo[pick_ch]};
            wr_bus.addr_ch <= pick_ch;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_start <= '0;
            pend_end   <= '0;
            pend_on    <= '0;
            pend_off   <= '0;
            up_cnt     <= '0;
            up_is_end  <= 1'b0;
        end else begin
            // A new write in the launch clock keeps its bit pending
            pend_start <= (pend_start & ~(pick_end ? '0 : launch_m)) |
                          (hit_start_hi ? wr_dec : '0);
            pend_end   <= (pend_end & ~(pick_end ? launch_m : '0)) |
                          (hit_end_hi ? wr_dec : '0);
            pend_on    <= (pend_on & ~slot_m & ~key_off_m) | key_on_m;
            pend_off   <= (pend_off & ~slot_m & ~key_on_m) | key_off_m;
            if (launch) begin
                up_cnt    <= 3'(num_ch);   // One full ring round
                up_is_end <= pick_end;
            end else if (cen && up_cnt != '0) begin
                up_cnt <= up_cnt - 1'b1;
            end
        end
    end

endmodule

//--- hw/adpcm_addr_cnt.sv
// Address counter that runs six channels through a slot pipeline and drives ROM and end flags
`timescale 1ns/1ps
module adpcm_addr_cnt (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  adpcm_pkg::ch_mask_t cur_ch,
    input  adpcm_pkg::ch_mask_t en_ch,
    adpcm_wr_if.cnt             wr_bus,
    output logic [19:0]         rom_addr,
    output logic [3:0]          rom_bank,
    output logic                rom_sel,
    output logic                rom_oe_n,
    output logic                decon,
    output logic                clr,
    output adpcm_pkg::ch_mask_t flags,
    input  adpcm_pkg::ch_mask_t flag_clr
);
    import adpcm_pkg::*;

    typedef struct packed {
        logic [naddr_w-1:0] addr;   // Bit 0 picks the nibble
        logic [bank_w-1:0]  bank;
        logic [start_w-1:0] start;
        logic [start_w-1:0] stop;   // End page
        logic               on;
        logic               done;
        logic               clr;
        logic               skip;   // Hold the address on the first fetch
    } stage_t;

    localparam stage_t idle_st = '{done: 1'b1, default: 0};

    stage_t   st [1:6];
    stage_t   nxt1;
    stage_t   nxt2;
    stage_t   nxt5;
    ch_mask_t addr_dec;
    logic     up1;
    logic     sumup5;
    logic     sumup6;
    logic     restart6;
    logic     fetch6;
    logic     roe_n1;
    logic     decon1;
    ch_mask_t done_sr;
    ch_mask_t last_done;
    ch_mask_t set_pulse;

    // All ROM side outputs come from stage 1
    assign rom_addr = st[1].addr[naddr_w-1:1];
    assign rom_sel  = st[1].addr[0];
    assign rom_bank = st[1].bank;
    assign rom_oe_n = roe_n1;
    assign decon    = decon1;
    assign clr      = st[1].clr;

    assign addr_dec = (wr_bus.addr_ch < 3'(num_ch)) ? ch_mask_t'(1) << wr_bus.addr_ch : '0;
    assign up1      = (cur_ch == addr_dec);
    assign sumup5   = st[5].on && !st[5].done;
    assign restart6 = st[6].clr && st[6].on;
    assign fetch6   = sumup6 && !restart6;  // Restart visit only reloads

    always_comb begin
        nxt2     = st[1];
        nxt2.on  = wr_bus.aoff ? 1'b0 : (wr_bus.aon | (st[1].on & ~st[1].done));
        nxt2.clr = wr_bus.aon & ~wr_bus.aoff;
        if (up1 && wr_bus.up_start) begin
            nxt2.start = wr_bus.addr_in[start_w-1:0];
            nxt2.bank  = wr_bus.addr_in[bank_w+start_w-1:start_w];
        end
        if (up1 && wr_bus.up_end)
            nxt2.stop = wr_bus.addr_in[start_w-1:0];
    end

    // End reached on the last nibble of the end page
    always_comb begin
        nxt5 = st[4];
        if (st[4].on)
            nxt5.done = (st[4].addr == {st[4].stop, {(naddr_w - start_w){1'b1}}}) && !st[4].clr;
    end

    always_comb begin
        nxt1     = st[6];
        nxt1.clr = restart6;
        if (restart6) begin
            nxt1.addr = {st[6].start, {(naddr_w - start_w){1'b0}}};
            nxt1.skip = 1'b1;
        end else if (sumup6) begin
            if (!st[6].skip)
                nxt1.addr = st[6].addr + 1'b1;
            nxt1.skip = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i <= 6; i++)
                st[i] <= idle_st;
            sumup6 <= 1'b0;
            roe_n1 <= 1'b1;
            decon1 <= 1'b0;
        end else if (cen) begin
            st[1]  <= nxt1;
            st[2]  <= nxt2;
            st[3]  <= st[2];
            st[4]  <= st[3];
            st[5]  <= nxt5;
            st[6]  <= st[5];
            sumup6 <= sumup5;
            roe_n1 <= !fetch6;
            decon1 <= fetch6;
        end
    end

    // Done bits of one round in channel order once slot 5 is in stage 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_sr   <= '1;
            last_done <= '1;
            set_pulse <= '0;
        end else begin
            set_pulse <= '0;
            if (cen) begin
                done_sr <= {done_sr[num_ch-2:0], st[1].done};
                if (cur_ch[num_ch-1]) begin
                    last_done <= done_sr;
                    set_pulse <= done_sr & ~last_done;  // Rising done bits only
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            flags <= '0;
        else
            flags <= (flags | set_pulse) & ~flag_clr;
    end

endmodule

//--- hw/adpcm_chan_level.sv
// Channel level store holding pan and level per channel for the slot in the ROM stage
`timescale 1ns/1ps
module adpcm_chan_level (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  adpcm_pkg::ch_mask_t cur_ch,
    input  logic                wr,
    input  logic [7:0]          reg_addr,
    input  logic [7:0]          din,
    output adpcm_pkg::lvl_t     slot_lvl
);
    import adpcm_pkg::*;

    lvl_t     lvl_q [num_ch];
    ch_mask_t nxt_ch;
    lvl_t     nxt_lvl;
    logic     lvl_wr;

    assign nxt_ch = {cur_ch[0], cur_ch[num_ch-1:1]};   // Slot entering stage 1
    assign lvl_wr = wr && (reg_addr[7:3] == reg_lvl_base[7:3]) && (reg_addr[2:0] < 3'(num_ch));

    always_comb begin
        nxt_lvl = '0;
        for (int i = 0; i < num_ch; i++) begin
            if (nxt_ch[i])
                nxt_lvl = lvl_q[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_ch; i++)
                lvl_q[i] <= '0;
            slot_lvl <= '0;
        end else begin
            if (lvl_wr)
                lvl_q[reg_addr[2:0]] <= '{pan: din[7:6], level: din[4:0]};
            if (cen)
                slot_lvl <= nxt_lvl;
        end
    end

endmodule

//--- hw/adpcm_slot_out.sv
// Slot output stage that captures ROM bytes and tags each nibble with channel, level and pan
`timescale 1ns/1ps
module adpcm_slot_out (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  adpcm_pkg::ch_mask_t cur_ch,
    input  logic                decon,
    input  logic                clr,
    input  logic                rom_sel,
    input  logic [7:0]          rom_data,
    input  adpcm_pkg::lvl_t     slot_lvl,
    output logic                slot_valid,
    output logic [3:0]          slot_nibble,
    output logic [2:0]          slot_ch,
    output adpcm_pkg::lvl_t     slot_lvl_o,
    output logic                slot_clr
);
    import adpcm_pkg::*;

    logic [2:0] ch_idx;

    always_comb begin
        ch_idx = '0;
        for (int i = 0; i < num_ch; i++) begin
            if (cur_ch[i])
                ch_idx = 3'(i);
        end
    end

    // ROM byte has settled by the tick that ends the stage 1 slot
    always_ff @(posedge clk) begin
        if (cen && (decon || clr)) begin
            slot_nibble <= rom_sel ? rom_data[3:0] : rom_data[7:4];  // High nibble first
            slot_ch     <= ch_idx;
            slot_lvl_o  <= slot_lvl;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
            slot_clr   <= 1'b0;
        end else begin
            slot_valid <= cen && decon;
            slot_clr   <= cen && clr;
        end
    end

endmodule

//--- hw/adpcm_a_top.sv
// ADPCM-A sample fetch front end joining sequencer, registers, counter, level store and output
`timescale 1ns/1ps
module adpcm_a_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr,
    input  logic [7:0]          reg_addr,
    input  logic [7:0]          din,
    output logic [19:0]         rom_addr,
    output logic [3:0]          rom_bank,
    output logic                rom_oe_n,
    input  logic [7:0]          rom_data,
    input  adpcm_pkg::ch_mask_t flag_clr,
    output adpcm_pkg::ch_mask_t flags,
    output logic                slot_valid,
    output logic [3:0]          slot_nibble,
    output logic [2:0]          slot_ch,
    output logic [1:0]          slot_pan,
    output logic [4:0]          slot_level,
    output logic                slot_clr
);
    import adpcm_pkg::*;

    logic     cen;
    ch_mask_t cur_ch;
    ch_mask_t en_ch;
    logic     rom_sel;
    logic     decon;
    logic     clr;
    lvl_t     slot_lvl;     // Stage 1 slot
    lvl_t     slot_lvl_o;   // Aligned with slot_nibble

    adpcm_wr_if wr_bus ();

    adpcm_ch_seq seq_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen),
        .cur_ch (cur_ch),
        .en_ch  (en_ch)
    );

    adpcm_cpu_regs regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .cur_ch   (cur_ch),
        .wr       (wr),
        .reg_addr (reg_addr),
        .din      (din),
        .wr_bus   (wr_bus.regs)
    );

    adpcm_addr_cnt cnt_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .cur_ch   (cur_ch),
        .en_ch    (en_ch),
        .wr_bus   (wr_bus.cnt),
        .rom_addr (rom_addr),
        .rom_bank (rom_bank),
        .rom_sel  (rom_sel),
        .rom_oe_n (rom_oe_n),
        .decon    (decon),
        .clr      (clr),
        .flags    (flags),
        .flag_clr (flag_clr)
    );

    adpcm_chan_level lvl_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .cur_ch   (cur_ch),
        .wr       (wr),
        .reg_addr (reg_addr),
        .din      (din),
        .slot_lvl (slot_lvl)
    );

    adpcm_slot_out out_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cen         (cen),
        .cur_ch      (cur_ch),
        .decon       (decon),
        .clr         (clr),
        .rom_sel     (rom_sel),
        .rom_data    (rom_data),
        .slot_lvl    (slot_lvl),
        .slot_valid  (slot_valid),
        .slot_nibble (slot_nibble),
        .slot_ch     (slot_ch),
        .slot_lvl_o  (slot_lvl_o),
        .slot_clr    (slot_clr)
    );

    assign slot_pan   = slot_lvl_o.pan;
    assign slot_level = slot_lvl_o.level;

endmodule

//--- testbench/adpcm_checker.sv
// Checker that rebuilds each channel's nibble stream from the ROM model and compares outputs
`timescale 1ns/1ps
module adpcm_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                wr,
    input logic [7:0]          reg_addr,
    input logic [7:0]          din,
    input logic                rom_oe_n,
    input adpcm_pkg::ch_mask_t flags,
    input logic                slot_valid,
    input logic [3:0]          slot_nibble,
    input logic [2:0]          slot_ch,
    input logic [1:0]          slot_pan,
    input logic [4:0]          slot_level,
    input logic                slot_clr
);
    import adpcm_pkg::*;

    localparam longint grace = 4 * num_ch * cen_div;   // Key-off drain time in clocks

    logic [7:0]  start_lo [num_ch];
    logic [7:0]  start_hi [num_ch];
    logic [7:0]  end_lo   [num_ch];
    logic [7:0]  end_hi   [num_ch];
    logic [7:0]  lvl_reg  [num_ch];
    int          on_cnt   [num_ch];
    int          clr_cnt  [num_ch];
    int          nib_cnt  [num_ch];
    bit          keyed_off[num_ch];
    longint      off_cyc  [num_ch];
    bit          playing  [num_ch];
    bit          finished [num_ch];
    bit          lo_phase [num_ch];
    logic [19:0] byte_ptr [num_ch];
    logic [3:0]  bank_q   [num_ch];
    logic [11:0] end_pg   [num_ch];
    longint      cyc;
    int          val_err;
    int          oth_err;
    int          nib_total;
    int          wc;
    int          vc;
    logic [7:0]  exp_byte;
    logic [3:0]  exp_nib;

    initial begin
        cyc = 0;
        val_err = 0;
        oth_err = 0;
        nib_total = 0;
        for (int i = 0; i < num_ch; i++) begin
            start_lo[i] = '0;
            start_hi[i] = '0;
            end_lo[i] = '0;
            end_hi[i] = '0;
            lvl_reg[i] = '0;
            on_cnt[i] = 0;
            clr_cnt[i] = 0;
            nib_cnt[i] = 0;
            keyed_off[i] = 1'b0;
            off_cyc[i] = 0;
            playing[i] = 1'b0;
            finished[i] = 1'b0;
            lo_phase[i] = 1'b0;
        end
    end

    task automatic value_fail(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        val_err++;
    endtask

    task automatic other_fail(input string msg);
        $display("ERROR: %s at %0t", msg, $time);
        oth_err++;
    endtask

    // Shadow copy of the CPU registers
    always @(posedge clk) begin
        cyc = cyc + 1;
        wc = reg_addr[2:0];
        if (rst_n && wr) begin
            if (reg_addr == reg_key) begin
                for (int i = 0; i < num_ch; i++) begin
                    if (din[i] && din[7]) begin
                        keyed_off[i] = 1'b1;
                        off_cyc[i] = cyc;
                    end else if (din[i]) begin
                        keyed_off[i] = 1'b0;
                        on_cnt[i]++;
                    end
                end
            end else if (wc < num_ch) begin
                case (reg_addr[7:3])
                    reg_lvl_base[7:3]:      lvl_reg[wc] = din;
                    reg_start_lo_base[7:3]: start_lo[wc] = din;
                    reg_start_hi_base[7:3]: start_hi[wc] = din;
                    reg_end_lo_base[7:3]:   end_lo[wc] = din;
                    reg_end_hi_base[7:3]:   end_hi[wc] = din;
                    default: ;
                endcase
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && slot_clr) begin
            vc = slot_ch;
            if (vc >= num_ch) begin
                other_fail("slot_clr with a channel index out of range");
            end else begin
                if (clr_cnt[vc] >= on_cnt[vc])
                    other_fail($sformatf("slot_clr on channel %0d without a key-on", vc));
                clr_cnt[vc]++;
                byte_ptr[vc] = {start_hi[vc][3:0], start_lo[vc], 8'h00};
                bank_q[vc]   = start_hi[vc][7:4];
                end_pg[vc]   = {end_hi[vc][3:0], end_lo[vc]};
                lo_phase[vc] = 1'b0;
                playing[vc]  = 1'b1;
                finished[vc] = 1'b0;
                nib_cnt[vc]  = 0;
            end
        end
        if (rst_n && slot_valid) begin
            vc = slot_ch;
            if (vc >= num_ch) begin
                other_fail("slot_valid with a channel index out of range");
            end else if (!playing[vc] || finished[vc]) begin
                other_fail($sformatf("slot_valid on channel %0d outside playback", vc));
            end else if (keyed_off[vc] && cyc > off_cyc[vc] + grace) begin
                other_fail($sformatf("slot_valid on channel %0d after key-off", vc));
            end else begin
                exp_byte = tb_adpcm_a.rom_mem[{bank_q[vc], byte_ptr[vc][15:0]}];
                exp_nib  = lo_phase[vc] ? exp_byte[3:0] : exp_byte[7:4];  // High first
                if (slot_nibble !== exp_nib)
                    value_fail($sformatf("slot_nibble ch%0d", vc), slot_nibble, exp_nib);
                if (slot_pan !== lvl_reg[vc][7:6])
                    value_fail($sformatf("slot_pan ch%0d", vc), slot_pan, lvl_reg[vc][7:6]);
                if (slot_level !== lvl_reg[vc][4:0])
                    value_fail($sformatf("slot_level ch%0d", vc), slot_level, lvl_reg[vc][4:0]);
                nib_cnt[vc]++;
                nib_total++;
                if (lo_phase[vc]) begin
                    if (byte_ptr[vc] == {end_pg[vc], 8'hFF})
                        finished[vc] = 1'b1;   // Last byte of the end page
                    byte_ptr[vc] = byte_ptr[vc] + 1'b1;
                end
                lo_phase[vc] = ~lo_phase[vc];
            end
        end
    end

    task automatic check_idle();
        if (rom_oe_n !== 1'b1)
            value_fail("rom_oe_n", rom_oe_n, 1);
        if (slot_valid !== 1'b0)
            value_fail("slot_valid", slot_valid, 0);
        if (slot_clr !== 1'b0)
            value_fail("slot_clr", slot_clr, 0);
        if (flags !== '0)
            value_fail("flags", flags, 0);
    endtask

    task automatic expect_flags(input ch_mask_t m);
        if (flags !== m)
            value_fail("flags", flags, m);
    endtask

    // 0xFFFF asks only for a nonzero count
    task automatic expect_count(input int c, input int n);
        if (on_cnt[c] != clr_cnt[c])
            other_fail($sformatf("key-on of channel %0d never restarted it", c));
        if (n == 'hFFFF) begin
            if (nib_cnt[c] == 0)
                other_fail($sformatf("channel %0d played no nibbles", c));
        end else if (nib_cnt[c] != n) begin
            value_fail($sformatf("nibble count ch%0d", c), nib_cnt[c], n);
        end
    endtask

    task automatic report();
        $display("Checker: %0d nibbles checked, %0d value errors, %0d other errors",
                 nib_total, val_err, oth_err);
    endtask

    function automatic int error_total();
        return val_err + oth_err;
    endfunction

endmodule

//--- testbench/tb_adpcm_a.sv
// ADPCM-A fetch testbench with clock, reset, ROM model, golden script and watchdog
`timescale 1ns/1ps
module tb_adpcm_a;
    import adpcm_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        wr;
    logic [7:0]  reg_addr;
    logic [7:0]  din;
    logic [19:0] rom_addr;
    logic [3:0]  rom_bank;
    logic        rom_oe_n;
    logic [7:0]  rom_data;
    ch_mask_t    flag_clr;
    ch_mask_t    flags;
    logic        slot_valid;
    logic [3:0]  slot_nibble;
    logic [2:0]  slot_ch;
    logic [1:0]  slot_pan;
    logic [4:0]  slot_level;
    logic        slot_clr;

    logic [7:0]  rom_mem [0:(1<<20)-1];  // Bank in the top nibble of the index
    logic [31:0] gold [0:255];            // op, arg, value
    integer      seed;
    int          rounds_total;
    int          idx;
    time         wd_limit;
    bit          wd_armed;

    always #4 clk = ~clk;

    assign rom_data = rom_oe_n ? 8'h00 : rom_mem[{rom_bank, rom_addr[15:0]}];

    adpcm_a_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (wr),
        .reg_addr    (reg_addr),
        .din         (din),
        .rom_addr    (rom_addr),
        .rom_bank    (rom_bank),
        .rom_oe_n    (rom_oe_n),
        .rom_data    (rom_data),
        .flag_clr    (flag_clr),
        .flags       (flags),
        .slot_valid  (slot_valid),
        .slot_nibble (slot_nibble),
        .slot_ch     (slot_ch),
        .slot_pan    (slot_pan),
        .slot_level  (slot_level),
        .slot_clr    (slot_clr)
    );

    adpcm_checker chk_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (wr),
        .reg_addr    (reg_addr),
        .din         (din),
        .rom_oe_n    (rom_oe_n),
        .flags       (flags),
        .slot_valid  (slot_valid),
        .slot_nibble (slot_nibble),
        .slot_ch     (slot_ch),
        .slot_pan    (slot_pan),
        .slot_level  (slot_level),
        .slot_clr    (slot_clr)
    );

    task automatic reg_write(input logic [7:0] a, input logic [7:0] d);
        @(negedge clk);
        wr       = 1'b1;
        reg_addr = a;
        din      = d;
        @(negedge clk);
        wr       = 1'b0;
    endtask

    task automatic wait_rounds(input int n);
        repeat (n * num_ch * cen_div) @(negedge clk);
    endtask

    task automatic pulse_flag_clr(input ch_mask_t m);
        @(negedge clk);
        flag_clr = m;
        @(negedge clk);
        flag_clr = '0;
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        wr       = 1'b0;
        reg_addr = '0;
        din      = '0;
        flag_clr = '0;
        seed     = 94483;
        wd_armed = 1'b0;
        for (int i = 0; i < (1 << 20); i++)
            rom_mem[i] = $random(seed);
        for (int i = 0; i < 256; i++)
            gold[i] = '0;
        $readmemh("testbench/adpcm_golden.txt", gold);
        rounds_total = 0;
        for (int i = 0; i < 256; i++) begin
            if (gold[i][31:24] == 8'h02)
                rounds_total += gold[i][15:0];
        end
        wd_limit = (rounds_total * num_ch * cen_div + 4000) * 8;  // One clock is 8 ns
        wd_armed = 1'b1;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        idx = 0;
        while (gold[idx][31:24] != 8'h00) begin
            case (gold[idx][31:24])
                8'h01:   reg_write(gold[idx][23:16], gold[idx][7:0]);
                8'h02:   wait_rounds(gold[idx][15:0]);
                8'h03:   pulse_flag_clr(gold[idx][num_ch-1:0]);
                8'h04:   chk_i.expect_flags(gold[idx][num_ch-1:0]);
                8'h05:   chk_i.expect_count(gold[idx][23:16], gold[idx][15:0]);
                8'h08:   chk_i.check_idle();
                default: chk_i.other_fail($sformatf("unknown golden opcode at word %0d", idx));
            endcase
            idx++;
        end
        chk_i.report();
        if (chk_i.error_total() == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // Watchdog sized from the golden waits
    initial begin
        wait (wd_armed);
        #(wd_limit);
        $display("Watchdog expired at %0t, the run did not complete", $time);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- files.f
hw/adpcm_pkg.sv
hw/adpcm_wr_if.sv
hw/adpcm_ch_seq.sv
hw/adpcm_cpu_regs.sv
hw/adpcm_addr_cnt.sv
hw/adpcm_chan_level.sv
hw/adpcm_slot_out.sv
hw/adpcm_a_top.sv
testbench/adpcm_checker.sv
testbench/tb_adpcm_a.sv

//--- testbench/adpcm_golden.txt
// One 32-bit word per command, op[31:24] arg[23:16] value[15:0]
// 01 write reg arg, 02 wait rounds, 03 flag_clr, 04 expect flags, 05 nibbles of ch arg, 08 idle
08000000
// Channel 0 alone, bank 1, page 0x012
01100012 01180010 01200012 01280010 0108009A
02000010
01000001 02000220
04000001 05000200
// Channel 2 keyed off in the middle of playback
01120040 011A0030 01220041 012A0030 010A004F
02000010
01000004 02000040 01000084 02000010
04000001 0502FFFF
// All six channels, channel 3 spans two pages
01100020 01180010 01200020 01280010 01080085
01110033 01190020 01210033 01290020 010900C3
01120050 011A0030 01220050 012A0030 010A0011
01130060 011B0040 01230061 012B0040 010B0047
01140005 011C0000 01240005 012C0000 010C009E
0115007F 011D00F0 0125007F 012D00F0 010D00D2
02000014
0100003F 02000420
0400003F 05000200 05010200 05020200 05030400 05040200 05050200
03000001 0400003E 0300003E 04000000
// Channel 1 restarted while playing
01000002 02000080 01000002 02000220
04000002 05010200
00000000
